//--- source/pim_pkg.sv
package pim_pkg;

    // register map
    localparam logic [31:0] PIM_MODE_ADDR   = 32'h4100_0000;
    localparam logic [31:0] PIM_ZP_ADDR     = 32'h4200_0000;
    localparam logic [31:0] PIM_STATUS_ADDR = 32'h4300_0000;
    localparam logic [31:0] PIM_RESULT_ADDR = 32'h4400_0000;
    localparam logic [11:0] PIM_CMD_REGION  = 12'h400;   // addr[31:20] of erase/program/read

    localparam int unsigned PIM_READ_CYCLES   = 9;
    localparam int unsigned PIM_ZP_CYCLES     = 1;
    localparam int unsigned PIM_READ_LOAD_CNT = 1;   // words left in the buffer by one read

    localparam int ROW_W      = 7;
    localparam int COL_W      = 9;
    localparam int PULSE_W_W  = 17;
    localparam int PULSE_C_W  = 5;
    localparam int EXEC_CNT_W = 4;
    localparam int LOAD_CNT_W = 6;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // 5 and 6 are reserved
    typedef enum logic [2:0] {
        PIM_NONE    = 3'd0,
        PIM_ERASE   = 3'd1,
        PIM_PROGRAM = 3'd2,
        PIM_READ    = 3'd3,
        PIM_ZP      = 3'd4,
        PIM_LOAD    = 3'd7
    } pim_mode_e;

    typedef struct packed {
        logic [11:0]      region;
        logic [3:0]       reserved;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } pim_cmd_addr_t;

    typedef struct packed {
        logic [9:0]           reserved;
        logic [PULSE_W_W-1:0] width;
        logic [PULSE_C_W-1:0] count;
    } pim_pulse_t;

    // command data is pulse settings or a zero-point word
    typedef union packed {
        pim_pulse_t  pulse;
        logic [31:0] zp;
    } pim_cmd_data_u;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                  en;
        pim_mode_e             mode;
        logic [ROW_W-1:0]      row;
        logic [COL_W-1:0]      col;
        logic [EXEC_CNT_W-1:0] exec_cnt;
    } pim_drive_t;

    typedef struct packed {
        logic        en;
        logic [31:0] value;
    } pim_zp_t;

    typedef struct packed {
        logic                  en;
        logic [LOAD_CNT_W-1:0] cnt;
    } pim_load_t;

endpackage

//--- source/axil_slave.sv
module axil_slave import pim_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,

    input  logic [31:0] wdata_i,
    input  logic        wvalid_i,
    output logic        wready_o,

    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,

    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,

    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,

    output bus_req_t    req_o,
    input  logic [31:0] rdata_i
);

    logic wr_acc;
    logic rd_acc;

    // write wins, nothing new while the own response is still pending
    assign wr_acc = awvalid_i && wvalid_i && !bvalid_o;
    assign rd_acc = arvalid_i && !rvalid_o && !wr_acc;

    assign awready_o = wr_acc;
    assign wready_o  = wr_acc;
    assign arready_o = rd_acc;

    always_comb begin
        req_o.wr    = wr_acc;
        req_o.rd    = rd_acc;
        req_o.addr  = wr_acc ? awaddr_i : araddr_i;
        req_o.wdata = wdata_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_acc) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_acc) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // held while rvalid waits for rready
    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            rdata_o <= rdata_i;
        end
    end

    assign bresp_o = AXI_RESP_OKAY;
    assign rresp_o = AXI_RESP_OKAY;

endmodule

//--- source/pim_sequencer.sv
module pim_sequencer import pim_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  bus_req_t              req_i,
    output logic [31:0]           rdata_o,
    input  logic [31:0]           out_buf_data_i,

    output logic                  start_o,
    output pim_mode_e             mode_o,
    output pim_cmd_addr_t         cmd_addr_o,
    output pim_cmd_data_u         cmd_data_o,
    output logic [LOAD_CNT_W-1:0] load_cnt_o,

    input  logic                  done_i,
    input  logic                  load_en_i
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MODE,
        READY,
        EXEC
    } state_e;

    state_e    state_q;
    pim_mode_e mode_q;
    pim_mode_e new_mode;
    logic      read_done_q;
    logic      load_en_q;
    logic [31:0] result_q;

    logic busy;
    logic status_rd;
    logic mode_wr;
    logic cmd_hit;
    logic cmd_start;
    logic load_start;

    assign cmd_addr_o    = pim_cmd_addr_t'(req_i.addr);
    assign cmd_data_o.zp = req_i.wdata;
    assign new_mode      = pim_mode_e'(req_i.wdata[2:0]);

    assign busy      = (state_q != IDLE);   // armed or running
    assign status_rd = req_i.rd && (req_i.addr == PIM_STATUS_ADDR);
    assign mode_wr   = req_i.wr && (req_i.addr == PIM_MODE_ADDR);

    always_comb begin
        cmd_hit = 1'b0;
        case (mode_q)
            PIM_ERASE, PIM_PROGRAM, PIM_READ: cmd_hit = (cmd_addr_o.region == PIM_CMD_REGION);
            PIM_ZP:                           cmd_hit = (req_i.addr == PIM_ZP_ADDR);
            default:                          cmd_hit = 1'b0;
        endcase
    end

    assign cmd_start  = (state_q == READY) && req_i.wr && cmd_hit;
    assign load_start = (state_q == WAIT_MODE) && mode_wr && (new_mode == PIM_LOAD);

    assign start_o    = cmd_start || load_start;
    assign mode_o     = load_start ? PIM_LOAD : mode_q;
    assign load_cnt_o = read_done_q ? LOAD_CNT_W'(PIM_READ_LOAD_CNT) : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            mode_q      <= PIM_NONE;
            read_done_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (status_rd && !busy) state_q <= WAIT_MODE;
                end
                WAIT_MODE: begin
                    if (mode_wr) begin
                        case (new_mode)
                            PIM_ERASE, PIM_PROGRAM, PIM_ZP: begin
                                mode_q      <= new_mode;
                                read_done_q <= 1'b0;
                                state_q     <= READY;
                            end
                            PIM_READ: begin
                                mode_q      <= new_mode;
                                read_done_q <= 1'b1;
                                state_q     <= READY;
                            end
                            PIM_LOAD: begin
                                mode_q  <= new_mode;   // read-done survives
                                state_q <= EXEC;
                            end
                            default: ;   // reserved codes, stay armed
                        endcase
                    end
                end
                READY: begin
                    if (cmd_start) state_q <= EXEC;
                end
                EXEC: begin
                    if (done_i) begin
                        state_q <= IDLE;
                        mode_q  <= PIM_NONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_en_q <= 1'b0;
        end else begin
            load_en_q <= load_en_i;
        end
    end

    // buffer word is valid the cycle after the load strobe
    always_ff @(posedge clk_i) begin
        if (load_en_q) result_q <= out_buf_data_i;
    end

    always_comb begin
        case (req_i.addr)
            PIM_STATUS_ADDR: rdata_o = {30'b0, 1'b1, !busy};
            PIM_RESULT_ADDR: rdata_o = result_q;
            default:         rdata_o = '0;
        endcase
    end

endmodule

//--- source/pim_exec_timer.sv
module pim_exec_timer import pim_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  start_i,
    input  pim_mode_e             mode_i,
    input  pim_cmd_addr_t         cmd_addr_i,
    input  pim_cmd_data_u         cmd_data_i,
    input  logic [LOAD_CNT_W-1:0] load_cnt_i,

    output logic                  done_o,
    output pim_drive_t            drive_o,
    output pim_zp_t               zp_o,
    output pim_load_t             load_o
);

    pim_mode_e             mode_q;
    logic [PULSE_W_W-1:0]  width_q;
    logic [PULSE_W_W-1:0]  init_width_q;
    logic [PULSE_C_W-1:0]  count_q;
    logic [EXEC_CNT_W-1:0] exec_q;
    logic [LOAD_CNT_W-1:0] load_q;
    logic [ROW_W-1:0]      row_q;
    logic [COL_W-1:0]      col_q;
    logic [31:0]           zp_q;

    always_comb begin
        case (mode_q)
            PIM_ERASE, PIM_PROGRAM: done_o = (count_q == '0);
            PIM_READ, PIM_ZP:       done_o = (exec_q == '0);
            PIM_LOAD:               done_o = (load_q == '0);
            default:                done_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mode_q  <= PIM_NONE;
            width_q <= '0;
            count_q <= '0;
            exec_q  <= '0;
            load_q  <= '0;
        end else if (start_i) begin
            mode_q  <= mode_i;
            width_q <= cmd_data_i.pulse.width;
            count_q <= cmd_data_i.pulse.count;
            exec_q  <= (mode_i == PIM_READ) ? EXEC_CNT_W'(PIM_READ_CYCLES)
                                            : EXEC_CNT_W'(PIM_ZP_CYCLES);
            load_q  <= load_cnt_i;
        end else if (done_o) begin
            mode_q <= PIM_NONE;
        end else begin
            case (mode_q)
                PIM_ERASE, PIM_PROGRAM: begin
                    if (width_q != '0) begin
                        width_q <= width_q - 1'b1;
                    end else begin
                        count_q <= count_q - 1'b1;   // one low cycle between pulses
                        width_q <= init_width_q;
                    end
                end
                PIM_READ, PIM_ZP: exec_q <= exec_q - 1'b1;
                PIM_LOAD:         load_q <= load_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            init_width_q <= cmd_data_i.pulse.width;
            row_q        <= cmd_addr_i.row;
            col_q        <= cmd_addr_i.col;
            zp_q         <= cmd_data_i.zp;
        end
    end

    // operands only show while the strobe is up
    always_comb begin
        drive_o = '0;
        zp_o    = '0;
        load_o  = '0;
        case (mode_q)
            PIM_ERASE, PIM_PROGRAM: begin
                if (count_q != '0 && width_q != '0) begin
                    drive_o.en   = 1'b1;
                    drive_o.mode = mode_q;
                    drive_o.row  = row_q;
                    drive_o.col  = (mode_q == PIM_PROGRAM) ? col_q : '0;
                end
            end
            PIM_READ: begin
                if (exec_q != '0) begin
                    drive_o.en       = 1'b1;
                    drive_o.mode     = mode_q;
                    drive_o.row      = row_q;
                    drive_o.col      = col_q;
                    drive_o.exec_cnt = exec_q;
                end
            end
            PIM_ZP: begin
                if (exec_q != '0) begin
                    zp_o.en    = 1'b1;
                    zp_o.value = zp_q;
                end
            end
            PIM_LOAD: begin
                if (load_q != '0) begin
                    load_o.en  = 1'b1;
                    load_o.cnt = load_q;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- source/pim_ctrl_top.sv
module pim_ctrl_top import pim_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,

    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,

    output pim_drive_t  drive_o,
    output pim_zp_t     zp_o,
    output pim_load_t   load_o,
    input  logic [31:0] out_buf_data_i
);

    bus_req_t              req;
    logic [31:0]           seq_rdata;
    logic                  start;
    pim_mode_e             mode;
    pim_cmd_addr_t         cmd_addr;
    pim_cmd_data_u         cmd_data;
    logic [LOAD_CNT_W-1:0] load_cnt;
    logic                  done;

    axil_slave u_axil_slave (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .req_o     (req),
        .rdata_i   (seq_rdata)
    );

    pim_sequencer u_pim_sequencer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (req),
        .rdata_o        (seq_rdata),
        .out_buf_data_i (out_buf_data_i),
        .start_o        (start),
        .mode_o         (mode),
        .cmd_addr_o     (cmd_addr),
        .cmd_data_o     (cmd_data),
        .load_cnt_o     (load_cnt),
        .done_i         (done),
        .load_en_i      (load_o.en)
    );

    pim_exec_timer u_pim_exec_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start),
        .mode_i     (mode),
        .cmd_addr_i (cmd_addr),
        .cmd_data_i (cmd_data),
        .load_cnt_i (load_cnt),
        .done_o     (done),
        .drive_o    (drive_o),
        .zp_o       (zp_o),
        .load_o     (load_o)
    );

endmodule

//--- tb/pim_ctrl_props.sv
module pim_ctrl_props import pim_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       bvalid_o,
    input logic       bready_i,
    input logic       rvalid_o,
    input logic       rready_i,
    input pim_drive_t drive_o,
    input pim_zp_t    zp_o,
    input pim_load_t  load_o
);
    timeunit 1ns;
    timeprecision 1ps;

    bvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bvalid_o && !bready_i |=> bvalid_o)
        else $error("bvalid_o dropped before bready_i");

    rvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_o && !rready_i |=> rvalid_o)
        else $error("rvalid_o dropped before rready_i");

    // row drivers and zero-point never share a cycle
    drive_zp_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(drive_o.en && zp_o.en))
        else $error("drive_o.en and zp_o.en high together");

    load_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_o.en |=> !load_o.en)
        else $error("load_o.en high for two cycles");

endmodule

bind pim_ctrl_top pim_ctrl_props u_props (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .drive_o  (drive_o),
    .zp_o     (zp_o),
    .load_o   (load_o)
);

//--- tb/pim_ctrl_tb.sv
module pim_ctrl_tb import pim_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        pim_mode_e        op;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [16:0]      width;
        logic [4:0]       count;
        logic [31:0]      zp_word;
        logic [31:0]      buf_word;
        logic [31:0]      exp_result;
        logic             res_valid;     // RESULT holds a captured word
        logic             load_strobe;
        logic [3:0]       bp;            // back-pressure cycles
        logic             pre_rsv;       // reserved mode code first
    } stim_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic [31:0] awaddr_i, wdata_i, araddr_i, out_buf_data_i;
    logic awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    logic [1:0] bresp_o, rresp_o;
    logic [31:0] rdata_o;
    pim_drive_t drive_o;
    pim_zp_t zp_o;
    pim_load_t load_o;

    stim_t tbl [11];
    logic [31:0] rand_state = 32'd56932;
    logic read_seen = 1'b0;
    logic have_result = 1'b0;
    logic [31:0] last_result = '0;
    int row_errs = 0, pass_cnt = 0, fail_cnt = 0;
    int cycles = 0, limit = 0;
    logic [31:0] rd;
    pim_mode_e op_v;

    int hi_cnt = 0, rise_cnt = 0, zp_cnt = 0, ld_cnt = 0;
    logic en_prev = 1'b0;
    pim_mode_e rise_mode;
    logic [ROW_W-1:0] rise_row;
    logic [COL_W-1:0] rise_col;
    logic [EXEC_CNT_W-1:0] rise_exec;
    logic [31:0] zp_val;
    logic [LOAD_CNT_W-1:0] ld_val;

    pim_ctrl_top dut (.*);

    always #50 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        if (drive_o.en) begin
            hi_cnt++;
            if (!en_prev) begin
                rise_cnt++;
                rise_mode = drive_o.mode;
                rise_row  = drive_o.row;
                rise_col  = drive_o.col;
                rise_exec = drive_o.exec_cnt;
            end
        end
        en_prev = drive_o.en;
        if (zp_o.en) begin
            zp_cnt++;
            zp_val = zp_o.value;
        end
        if (load_o.en) begin
            ld_cnt++;
            ld_val = load_o.cnt;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int busy_cycles(input stim_t t);
        case (t.op)
            PIM_ERASE, PIM_PROGRAM: return int'(t.count) * (int'(t.width) + 1) + 1;
            PIM_READ:               return int'(PIM_READ_CYCLES) + 1;
            default:                return 3;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        $display("mismatch at %0d ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        row_errs++;
    endtask

    task automatic add_row(input int i, input pim_mode_e op, input int row, col, width, count,
                           input int bp, input logic rsv);
        tbl[i].op      = op;
        tbl[i].row     = 7'(row);
        tbl[i].col     = 9'(col);
        tbl[i].width   = 17'(width);
        tbl[i].count   = 5'(count);
        tbl[i].bp      = 4'(bp);
        tbl[i].pre_rsv = rsv;
        rand_state = lcg_next(rand_state);
        tbl[i].zp_word = rand_state;
        rand_state = lcg_next(rand_state);
        tbl[i].buf_word = rand_state;
        // a load strobes only when a read came before it
        tbl[i].load_strobe = (op == PIM_LOAD) && read_seen;
        if (tbl[i].load_strobe) begin
            last_result = tbl[i].buf_word;
            have_result = 1'b1;
        end
        tbl[i].exp_result = last_result;
        tbl[i].res_valid  = have_result;
        if (op == PIM_READ) read_seen = 1'b1;
        else if (op != PIM_LOAD) read_seen = 1'b0;
    endtask

    task automatic build_table();
        add_row(0, PIM_ERASE, 5, 17, 3, 2, 0, 1'b0);
        add_row(1, PIM_LOAD, 0, 0, 0, 0, 0, 1'b0);      // after erase, no strobe
        add_row(2, PIM_READ, 33, 300, 0, 0, 3, 1'b0);
        add_row(3, PIM_LOAD, 0, 0, 0, 0, 4, 1'b0);
        add_row(4, PIM_ZP, 0, 0, 0, 0, 0, 1'b0);
        add_row(5, PIM_PROGRAM, 100, 411, 5, 3, 0, 1'b1);
        add_row(6, PIM_LOAD, 0, 0, 0, 0, 2, 1'b0);
        add_row(7, PIM_READ, 127, 511, 0, 0, 0, 1'b0);
        add_row(8, PIM_LOAD, 0, 0, 0, 0, 2, 1'b0);
        add_row(9, PIM_ZP, 0, 0, 0, 0, 2, 1'b1);
        add_row(10, PIM_PROGRAM, 64, 256, 1, 4, 0, 1'b0);
    endtask

    task automatic axil_write(input logic [31:0] addr, data, input int bp);
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        bready_i  = 1'b0;
        @(negedge clk_i);
        while (!bvalid_o) @(negedge clk_i);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        repeat (bp) @(negedge clk_i);
        if (bvalid_o !== 1'b1) report_mismatch("bvalid_o", 32'd1, 32'(bvalid_o));
        if (bresp_o !== AXI_RESP_OKAY) report_mismatch("bresp_o", 32'd0, 32'(bresp_o));
        bready_i = 1'b1;
        @(negedge clk_i);
        bready_i = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, input int bp, output logic [31:0] data);
        araddr_i  = addr;
        arvalid_i = 1'b1;
        rready_i  = 1'b0;
        @(negedge clk_i);
        while (!rvalid_o) @(negedge clk_i);
        arvalid_i = 1'b0;
        data = rdata_o;
        repeat (bp) @(negedge clk_i);
        if (rdata_o !== data) report_mismatch("rdata_o under back-pressure", data, rdata_o);
        if (rresp_o !== AXI_RESP_OKAY) report_mismatch("rresp_o", 32'd0, 32'(rresp_o));
        rready_i = 1'b1;
        @(negedge clk_i);
        rready_i = 1'b0;
    endtask

    // the read that sees idle also arms the next operation
    task automatic wait_idle(output int busy_reads);
        logic [31:0] st;
        logic done;
        busy_reads = 0;
        done = 1'b0;
        while (!done) begin
            axil_read(PIM_STATUS_ADDR, 0, st);
            if (st === 32'd2) begin
                busy_reads++;
            end else begin
                if (st !== 32'd3) report_mismatch("STATUS", 32'd3, st);
                done = 1'b1;
            end
        end
    endtask

    task automatic run_row(input int idx);
        stim_t t;
        pim_mode_e op;
        logic [31:0] res;
        logic [COL_W-1:0] exp_col;
        int hi0, rise0, zp0, ld0, busy_reads, exp_hi, exp_rise, exp_zp, exp_ld;
        t = tbl[idx];
        op = t.op;
        hi0 = hi_cnt;
        rise0 = rise_cnt;
        zp0 = zp_cnt;
        ld0 = ld_cnt;
        out_buf_data_i = t.buf_word;
        if (t.pre_rsv) begin
            axil_write(PIM_MODE_ADDR, 32'd5, 0);
            axil_read(PIM_STATUS_ADDR, 0, res);
            if (res !== 32'd2) report_mismatch("STATUS after reserved mode", 32'd2, res);
        end
        axil_write(PIM_MODE_ADDR, 32'(op), int'(t.bp));
        if (op == PIM_ZP) begin
            axil_write(PIM_ZP_ADDR, t.zp_word, 0);
        end else if (op != PIM_LOAD) begin
            axil_write({PIM_CMD_REGION, 4'h0, t.row, t.col}, {10'h0, t.width, t.count}, 0);
        end
        wait_idle(busy_reads);

        exp_hi = 0;
        exp_rise = 0;
        if (op == PIM_ERASE || op == PIM_PROGRAM) begin
            exp_hi = int'(t.count) * int'(t.width);
            exp_rise = int'(t.count);
        end else if (op == PIM_READ) begin
            exp_hi = int'(PIM_READ_CYCLES);
            exp_rise = 1;
        end
        if (hi_cnt - hi0 != exp_hi)
            report_mismatch("drive_o.en high cycles", 32'(exp_hi), 32'(hi_cnt - hi0));
        if (rise_cnt - rise0 != exp_rise)
            report_mismatch("drive_o.en rising edges", 32'(exp_rise), 32'(rise_cnt - rise0));
        if (exp_rise > 0) begin
            exp_col = (op == PIM_ERASE) ? '0 : t.col;
            if (rise_mode !== op)
                report_mismatch("drive_o.mode", 32'(op), 32'(rise_mode));
            if (rise_row !== t.row)
                report_mismatch("drive_o.row", 32'(t.row), 32'(rise_row));
            if (rise_col !== exp_col)
                report_mismatch("drive_o.col", 32'(exp_col), 32'(rise_col));
            if (busy_reads == 0) begin
                $display("%0d ns: STATUS never read busy while the operation ran", $time);
                row_errs++;
            end
        end
        if (op == PIM_READ && rise_exec !== 4'd9)
            report_mismatch("drive_o.exec_cnt", 32'd9, 32'(rise_exec));
        exp_zp = (op == PIM_ZP) ? 1 : 0;
        if (zp_cnt - zp0 != exp_zp)
            report_mismatch("zp_o.en strobes", 32'(exp_zp), 32'(zp_cnt - zp0));
        if (op == PIM_ZP && zp_val !== t.zp_word)
            report_mismatch("zp_o.value", t.zp_word, zp_val);
        exp_ld = t.load_strobe ? 1 : 0;
        if (ld_cnt - ld0 != exp_ld)
            report_mismatch("load_o.en strobes", 32'(exp_ld), 32'(ld_cnt - ld0));
        if (t.load_strobe && ld_val !== 6'd1)
            report_mismatch("load_o.cnt", 32'd1, 32'(ld_val));
        if (op == PIM_LOAD && t.res_valid) begin
            axil_read(PIM_RESULT_ADDR, int'(t.bp), res);
            if (res !== t.exp_result) report_mismatch("RESULT", t.exp_result, res);
        end
    endtask

    task automatic finish_test(input string name);
        if (row_errs == 0) begin
            pass_cnt++;
            $display("%s: pass", name);
        end else begin
            fail_cnt++;
            $display("%s: fail with %0d errors", name, row_errs);
        end
        row_errs = 0;
    endtask

    initial begin
        rst_ni = 1'b0;
        awaddr_i = '0;
        wdata_i = '0;
        araddr_i = '0;
        out_buf_data_i = '0;
        awvalid_i = 1'b0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        build_table();
        for (int i = 0; i < $size(tbl); i++) limit += busy_cycles(tbl[i]) + 60;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;

        if (drive_o.en || zp_o.en || load_o.en || awready_o || wready_o || arready_o ||
            bvalid_o || rvalid_o) begin
            $display("%0d ns: an enable, ready or valid output was high after reset", $time);
            row_errs++;
        end
        axil_read(PIM_STATUS_ADDR, 0, rd);   // arms the first row
        if (rd !== 32'd3) report_mismatch("STATUS", 32'd3, rd);
        finish_test("reset and STATUS");

        for (int i = 0; i < $size(tbl); i++) begin
            op_v = tbl[i].op;
            run_row(i);
            finish_test($sformatf("row %0d %s", i, op_v.name()));
        end

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/pim_pkg.sv
source/axil_slave.sv
source/pim_sequencer.sv
source/pim_exec_timer.sv
source/pim_ctrl_top.sv
tb/pim_ctrl_props.sv
tb/pim_ctrl_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module pim_ctrl_tb \
    -f verilog.f -o pim_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/pim_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
